// File: src/riscv_isa_pkg.sv
package riscv_isa_pkg;

  ////////////////////
  // instruction word

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_fields_type;

  // same 32 bits, seen whole or split into R/I/S/B fields
  typedef union packed {
    logic [31:0] raw;
    instr_fields_type fields;
  } instr_word_type;

  ////////////////////
  // opcodes

  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // integer funct3
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl = 3'b101; // also sra
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra

  // full system words
  localparam logic [31:0] instr_ecall = 32'h00000073;
  localparam logic [31:0] instr_ebreak = 32'h00100073;
  localparam logic [31:0] nop_instr = 32'h00000013; // addi x0, x0, 0

  ////////////////////
  // exception causes

  localparam logic [3:0] except_illegal_instruction = 4'd2;
  localparam logic [3:0] except_breakpoint = 4'd3;
  localparam logic [3:0] except_env_call_mach = 4'd11;

endpackage

// File: src/decode_pkg.sv
package decode_pkg;

  ////////////////////
  // operation flags

  localparam int op_width = 12;

  localparam int op_wren = 0;
  localparam int op_rden1 = 1;
  localparam int op_rden2 = 2;
  localparam int op_lui = 3;
  localparam int op_auipc = 4;
  localparam int op_jal = 5;
  localparam int op_jalr = 6;
  localparam int op_branch = 7;
  localparam int op_load = 8;
  localparam int op_store = 9;
  localparam int op_ecall = 10;
  localparam int op_ebreak = 11;

  ////////////////////
  // alu operations

  localparam logic [3:0] alu_add = 4'd0;
  localparam logic [3:0] alu_sub = 4'd1;
  localparam logic [3:0] alu_sll = 4'd2;
  localparam logic [3:0] alu_slt = 4'd3;
  localparam logic [3:0] alu_sltu = 4'd4;
  localparam logic [3:0] alu_xor = 4'd5;
  localparam logic [3:0] alu_srl = 4'd6;
  localparam logic [3:0] alu_sra = 4'd7;
  localparam logic [3:0] alu_or = 4'd8;
  localparam logic [3:0] alu_and = 4'd9;

  // bcu and lsu operations carry funct3 unchanged

endpackage

// File: src/instr_decoder.sv
module instr_decoder (
  input riscv_isa_pkg::instr_word_type instr,
  output logic [decode_pkg::op_width-1:0] flags,
  output logic valid,
  output logic [31:0] imm,
  output logic [3:0] alu_op,
  output logic [2:0] bcu_op,
  output logic [2:0] lsu_op
);
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [2:0] funct3;
  logic [6:0] funct7;

  function automatic logic [3:0] alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      funct3_add: return alt ? alu_sub : alu_add;
      funct3_sll: return alu_sll;
      funct3_slt: return alu_slt;
      funct3_sltu: return alu_sltu;
      funct3_xor: return alu_xor;
      funct3_srl: return alt ? alu_sra : alu_srl;
      funct3_or: return alu_or;
      funct3_and: return alu_and;
      default: return alu_add;
    endcase
  endfunction

  assign funct3 = instr.fields.funct3;
  assign funct7 = instr.fields.funct7;

  ////////////////////
  // immediates

  assign imm_i = {{20{instr.raw[31]}}, instr.raw[31:20]};
  assign imm_s = {{20{instr.raw[31]}}, instr.raw[31:25], instr.raw[11:7]};
  assign imm_b = {{19{instr.raw[31]}}, instr.raw[31], instr.raw[7], instr.raw[30:25],
                  instr.raw[11:8], 1'b0};
  assign imm_u = {instr.raw[31:12], 12'h000};
  assign imm_j = {{11{instr.raw[31]}}, instr.raw[31], instr.raw[19:12], instr.raw[20],
                  instr.raw[30:21], 1'b0};

  ////////////////////
  // opcode decode

  // opcode and flag names overlap between the packages, so both are scoped here
  always_comb begin
    flags = '0;
    valid = 1'b0;
    imm = '0;
    alu_op = alu_add;
    bcu_op = 3'b000;
    lsu_op = 3'b000;
    case (instr.fields.opcode)
      riscv_isa_pkg::op_lui: begin
        flags[op_wren] = 1'b1;
        flags[decode_pkg::op_lui] = 1'b1;
        imm = imm_u;
        valid = 1'b1;
      end
      riscv_isa_pkg::op_auipc: begin
        flags[op_wren] = 1'b1;
        flags[decode_pkg::op_auipc] = 1'b1;
        imm = imm_u;
        valid = 1'b1;
      end
      riscv_isa_pkg::op_jal: begin
        flags[op_wren] = 1'b1;
        flags[decode_pkg::op_jal] = 1'b1;
        imm = imm_j;
        valid = 1'b1;
      end
      riscv_isa_pkg::op_jalr: begin
        flags[op_wren] = 1'b1;
        flags[op_rden1] = 1'b1;
        flags[decode_pkg::op_jalr] = 1'b1;
        imm = imm_i;
        valid = funct3 == 3'b000;
      end
      riscv_isa_pkg::op_branch: begin
        flags[op_rden1] = 1'b1;
        flags[op_rden2] = 1'b1;
        flags[decode_pkg::op_branch] = 1'b1;
        imm = imm_b;
        bcu_op = funct3;
        valid = funct3[2:1] != 2'b01; // no 010 / 011 compare
      end
      riscv_isa_pkg::op_load: begin
        flags[op_wren] = 1'b1;
        flags[op_rden1] = 1'b1;
        flags[decode_pkg::op_load] = 1'b1;
        imm = imm_i;
        lsu_op = funct3;
        valid = funct3 != 3'b011 && funct3[2:1] != 2'b11; // lb lh lw lbu lhu
      end
      riscv_isa_pkg::op_store: begin
        flags[op_rden1] = 1'b1;
        flags[op_rden2] = 1'b1;
        flags[decode_pkg::op_store] = 1'b1;
        imm = imm_s;
        lsu_op = funct3;
        valid = funct3[2] == 1'b0 && funct3 != 3'b011; // sb sh sw
      end
      riscv_isa_pkg::op_imm: begin
        flags[op_wren] = 1'b1;
        flags[op_rden1] = 1'b1;
        imm = imm_i;
        alu_op = alu_decode(funct3, funct3 == funct3_srl && funct7 == funct7_alt);
        case (funct3)
          funct3_sll: valid = funct7 == funct7_base;
          funct3_srl: valid = funct7 == funct7_base || funct7 == funct7_alt;
          default: valid = 1'b1;
        endcase
      end
      riscv_isa_pkg::op_reg: begin
        flags[op_wren] = 1'b1;
        flags[op_rden1] = 1'b1;
        flags[op_rden2] = 1'b1;
        alu_op = alu_decode(funct3, funct7 == funct7_alt);
        valid = funct7 == funct7_base ||
                (funct7 == funct7_alt && (funct3 == funct3_add || funct3 == funct3_srl));
      end
      riscv_isa_pkg::op_system: begin
        if (instr.raw == instr_ecall) begin
          flags[op_ecall] = 1'b1;
          valid = 1'b1;
        end else if (instr.raw == instr_ebreak) begin
          flags[op_ebreak] = 1'b1;
          valid = 1'b1;
        end
      end
      default: ;
    endcase
    if (!valid) begin
      flags = '0; // illegal word carries no operation
    end
  end

endmodule

// File: src/hazard_check.sv
module hazard_check (
  input logic rden1_0,
  input logic rden2_0,
  input logic rden1_1,
  input logic rden2_1,
  input logic [4:0] raddr1_0,
  input logic [4:0] raddr2_0,
  input logic [4:0] raddr1_1,
  input logic [4:0] raddr2_1,
  input logic ex_load0,
  input logic ex_load1,
  input logic [4:0] ex_waddr0,
  input logic [4:0] ex_waddr1,
  output logic hazard
);

  logic hit0;
  logic hit1;

  // any enabled source of either decode slot against one load destination
  function automatic logic uses(input logic [4:0] waddr);
    return (rden1_0 && raddr1_0 == waddr) || (rden2_0 && raddr2_0 == waddr) ||
           (rden1_1 && raddr1_1 == waddr) || (rden2_1 && raddr2_1 == waddr);
  endfunction

  assign hit0 = ex_load0 && ex_waddr0 != 5'd0 && uses(ex_waddr0); // x0 never stalls
  assign hit1 = ex_load1 && ex_waddr1 != 5'd0 && uses(ex_waddr1);
  assign hazard = hit0 | hit1;

endmodule

// File: src/register_file.sv
module register_file (
  input logic clock,
  input logic reset,
  input logic [4:0] raddr1_0,
  input logic [4:0] raddr2_0,
  input logic [4:0] raddr1_1,
  input logic [4:0] raddr2_1,
  output logic [31:0] rdata1_0,
  output logic [31:0] rdata2_0,
  output logic [31:0] rdata1_1,
  output logic [31:0] rdata2_1,
  input logic wren0,
  input logic wren1,
  input logic [4:0] waddr0,
  input logic [4:0] waddr1,
  input logic [31:0] wdata0,
  input logic [31:0] wdata1
);

  logic [31:0] regs [1:31]; // x0 has no storage

  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end
    return regs[addr];
  endfunction

  assign rdata1_0 = read_reg(raddr1_0);
  assign rdata2_0 = read_reg(raddr2_0);
  assign rdata1_1 = read_reg(raddr1_1);
  assign rdata2_1 = read_reg(raddr2_1);

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wren0 && waddr0 != 5'd0) begin
        regs[waddr0] <= wdata0;
      end
      if (wren1 && waddr1 != 5'd0) begin
        regs[waddr1] <= wdata1; // later slot wins on same address
      end
    end
  end

endmodule

// File: src/decode_stage.sv
module decode_stage (
  input logic clock,
  input logic reset,
  input logic [31:0] pc0, pc1,
  input riscv_isa_pkg::instr_word_type instr0, instr1,
  input logic in_valid,
  input logic pred_branch,
  input logic clear,
  input logic ex_stall,
  input logic hazard,
  input logic [decode_pkg::op_width-1:0] flags0, flags1,
  input logic valid0, valid1,
  input logic [31:0] imm0, imm1,
  input logic [3:0] alu_op0, alu_op1,
  input logic [2:0] bcu_op0, bcu_op1,
  input logic [2:0] lsu_op0, lsu_op1,
  output riscv_isa_pkg::instr_word_type word0, word1,
  output logic rden1_0, rden2_0, rden1_1, rden2_1,
  output logic [4:0] raddr1_0, raddr2_0, raddr1_1, raddr2_1,
  output logic [4:0] rf_raddr1_0, rf_raddr2_0, rf_raddr1_1, rf_raddr2_1,
  output logic [31:0] dec_pc0, dec_pc1,
  output logic [31:0] dec_instr0, dec_instr1,
  output logic [decode_pkg::op_width-1:0] dec_flags0, dec_flags1,
  output logic dec_valid0, dec_valid1,
  output logic [31:0] dec_imm0, dec_imm1,
  output logic [3:0] dec_alu_op0, dec_alu_op1,
  output logic [2:0] dec_bcu_op0, dec_bcu_op1,
  output logic [2:0] dec_lsu_op0, dec_lsu_op1,
  output logic dec_exception0, dec_exception1,
  output logic [3:0] dec_ecause0, dec_ecause1,
  output logic stall
);
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  instr_word_type reg_word0;
  instr_word_type reg_word1;
  logic bubble;
  logic drop1;
  logic exc0;
  logic [3:0] cause0;

  ////////////////////
  // decode side

  assign word0 = instr0;
  assign word1 = instr1;

  // sources towards the hazard check, killed slot 1 never stalls
  assign rden1_0 = in_valid & flags0[op_rden1];
  assign rden2_0 = in_valid & flags0[op_rden2];
  assign rden1_1 = in_valid & ~pred_branch & flags1[op_rden1];
  assign rden2_1 = in_valid & ~pred_branch & flags1[op_rden2];
  assign raddr1_0 = instr0.fields.rs1;
  assign raddr2_0 = instr0.fields.rs2;
  assign raddr1_1 = instr1.fields.rs1;
  assign raddr2_1 = instr1.fields.rs2;

  assign stall = hazard & ~clear;
  assign bubble = hazard | ex_stall | clear | ~in_valid;
  assign drop1 = bubble | pred_branch;

  // slot 0 priority illegal > breakpoint > ecall
  always_comb begin
    exc0 = 1'b1;
    cause0 = except_illegal_instruction;
    if (!valid0) begin
      cause0 = except_illegal_instruction;
    end else if (flags0[op_ebreak]) begin
      cause0 = except_breakpoint;
    end else if (flags0[op_ecall]) begin
      cause0 = except_env_call_mach;
    end else begin
      exc0 = 1'b0;
      cause0 = 4'd0;
    end
  end

  ////////////////////
  // pipeline register

  always_ff @(posedge clock) begin
    if (!reset) begin
      dec_flags0 <= '0;
      dec_flags1 <= '0;
      dec_valid0 <= 1'b0;
      dec_valid1 <= 1'b0;
      dec_exception0 <= 1'b0;
      dec_exception1 <= 1'b0;
    end else begin
      dec_flags0 <= bubble ? '0 : flags0;
      dec_flags1 <= drop1 ? '0 : flags1;
      dec_valid0 <= ~bubble & valid0;
      dec_valid1 <= ~drop1 & valid1;
      dec_exception0 <= ~bubble & exc0;
      dec_exception1 <= ~drop1 & ~valid1; // slot 1 reports illegal only
    end
  end

  always_ff @(posedge clock) begin
    dec_pc0 <= pc0;
    dec_pc1 <= pc1;
    reg_word0 <= instr0;
    reg_word1 <= pred_branch ? nop_instr : instr1;
    dec_imm0 <= imm0;
    dec_imm1 <= imm1;
    dec_alu_op0 <= alu_op0;
    dec_alu_op1 <= alu_op1;
    dec_bcu_op0 <= bcu_op0;
    dec_bcu_op1 <= bcu_op1;
    dec_lsu_op0 <= lsu_op0;
    dec_lsu_op1 <= lsu_op1;
    dec_ecause0 <= cause0;
    dec_ecause1 <= valid1 ? 4'd0 : except_illegal_instruction;
  end

  assign dec_instr0 = reg_word0.raw;
  assign dec_instr1 = reg_word1.raw;

  // operand reads use the registered pair
  assign rf_raddr1_0 = reg_word0.fields.rs1;
  assign rf_raddr2_0 = reg_word0.fields.rs2;
  assign rf_raddr1_1 = reg_word1.fields.rs1;
  assign rf_raddr2_1 = reg_word1.fields.rs2;

  assert property (@(posedge clock) disable iff (!reset) dec_exception0 |-> dec_ecause0 != 4'd0)
    else $error("slot 0 exception without cause");
  assert property (@(posedge clock) disable iff (!reset) dec_exception1 |-> dec_ecause1 != 4'd0)
    else $error("slot 1 exception without cause");

endmodule

// File: src/decode_top.sv
module decode_top (
  input logic clock,
  input logic reset,
  input logic [31:0] fetch_pc0, fetch_pc1,
  input logic [31:0] fetch_instr0, fetch_instr1,
  input logic fetch_valid,
  input logic pred_branch,
  input logic clear,
  input logic ex_load0, ex_load1,
  input logic [4:0] ex_waddr0, ex_waddr1,
  input logic ex_stall,
  input logic wb_wren0, wb_wren1,
  input logic [4:0] wb_waddr0, wb_waddr1,
  input logic [31:0] wb_wdata0, wb_wdata1,
  output logic [31:0] dec_pc0, dec_pc1,
  output logic [31:0] dec_instr0, dec_instr1,
  output logic [decode_pkg::op_width-1:0] dec_flags0, dec_flags1,
  output logic dec_valid0, dec_valid1,
  output logic [31:0] dec_imm0, dec_imm1,
  output logic [3:0] dec_alu_op0, dec_alu_op1,
  output logic [2:0] dec_bcu_op0, dec_bcu_op1,
  output logic [2:0] dec_lsu_op0, dec_lsu_op1,
  output logic dec_exception0, dec_exception1,
  output logic [3:0] dec_ecause0, dec_ecause1,
  output logic [31:0] dec_rdata1_0, dec_rdata2_0, dec_rdata1_1, dec_rdata2_1,
  output logic stall
);
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  instr_word_type word0;
  instr_word_type word1;
  logic [op_width-1:0] flags0;
  logic [op_width-1:0] flags1;
  logic valid0;
  logic valid1;
  logic [31:0] imm0;
  logic [31:0] imm1;
  logic [3:0] alu_op0;
  logic [3:0] alu_op1;
  logic [2:0] bcu_op0;
  logic [2:0] bcu_op1;
  logic [2:0] lsu_op0;
  logic [2:0] lsu_op1;
  logic rden1_0;
  logic rden2_0;
  logic rden1_1;
  logic rden2_1;
  logic [4:0] raddr1_0;
  logic [4:0] raddr2_0;
  logic [4:0] raddr1_1;
  logic [4:0] raddr2_1;
  logic [4:0] rf_raddr1_0;
  logic [4:0] rf_raddr2_0;
  logic [4:0] rf_raddr1_1;
  logic [4:0] rf_raddr2_1;
  logic hazard;

  ////////////////////
  // per-slot decoders

  instr_decoder decoder0_inst (
    .instr(word0), .flags(flags0), .valid(valid0), .imm(imm0),
    .alu_op(alu_op0), .bcu_op(bcu_op0), .lsu_op(lsu_op0)
  );

  instr_decoder decoder1_inst (
    .instr(word1), .flags(flags1), .valid(valid1), .imm(imm1),
    .alu_op(alu_op1), .bcu_op(bcu_op1), .lsu_op(lsu_op1)
  );

  hazard_check hazard_check_inst (
    .rden1_0(rden1_0), .rden2_0(rden2_0), .rden1_1(rden1_1), .rden2_1(rden2_1),
    .raddr1_0(raddr1_0), .raddr2_0(raddr2_0), .raddr1_1(raddr1_1), .raddr2_1(raddr2_1),
    .ex_load0(ex_load0), .ex_load1(ex_load1),
    .ex_waddr0(ex_waddr0), .ex_waddr1(ex_waddr1),
    .hazard(hazard)
  );

  ////////////////////
  // stage and operands

  decode_stage decode_stage_inst (
    .clock(clock), .reset(reset),
    .pc0(fetch_pc0), .pc1(fetch_pc1), .instr0(fetch_instr0), .instr1(fetch_instr1),
    .in_valid(fetch_valid), .pred_branch(pred_branch), .clear(clear),
    .ex_stall(ex_stall), .hazard(hazard),
    .flags0(flags0), .flags1(flags1), .valid0(valid0), .valid1(valid1),
    .imm0(imm0), .imm1(imm1), .alu_op0(alu_op0), .alu_op1(alu_op1),
    .bcu_op0(bcu_op0), .bcu_op1(bcu_op1), .lsu_op0(lsu_op0), .lsu_op1(lsu_op1),
    .word0(word0), .word1(word1),
    .rden1_0(rden1_0), .rden2_0(rden2_0), .rden1_1(rden1_1), .rden2_1(rden2_1),
    .raddr1_0(raddr1_0), .raddr2_0(raddr2_0), .raddr1_1(raddr1_1), .raddr2_1(raddr2_1),
    .rf_raddr1_0(rf_raddr1_0), .rf_raddr2_0(rf_raddr2_0),
    .rf_raddr1_1(rf_raddr1_1), .rf_raddr2_1(rf_raddr2_1),
    .dec_pc0(dec_pc0), .dec_pc1(dec_pc1), .dec_instr0(dec_instr0), .dec_instr1(dec_instr1),
    .dec_flags0(dec_flags0), .dec_flags1(dec_flags1),
    .dec_valid0(dec_valid0), .dec_valid1(dec_valid1),
    .dec_imm0(dec_imm0), .dec_imm1(dec_imm1),
    .dec_alu_op0(dec_alu_op0), .dec_alu_op1(dec_alu_op1),
    .dec_bcu_op0(dec_bcu_op0), .dec_bcu_op1(dec_bcu_op1),
    .dec_lsu_op0(dec_lsu_op0), .dec_lsu_op1(dec_lsu_op1),
    .dec_exception0(dec_exception0), .dec_exception1(dec_exception1),
    .dec_ecause0(dec_ecause0), .dec_ecause1(dec_ecause1),
    .stall(stall)
  );

  register_file register_file_inst (
    .clock(clock), .reset(reset),
    .raddr1_0(rf_raddr1_0), .raddr2_0(rf_raddr2_0),
    .raddr1_1(rf_raddr1_1), .raddr2_1(rf_raddr2_1),
    .rdata1_0(dec_rdata1_0), .rdata2_0(dec_rdata2_0),
    .rdata1_1(dec_rdata1_1), .rdata2_1(dec_rdata2_1),
    .wren0(wb_wren0), .wren1(wb_wren1), .waddr0(wb_waddr0), .waddr1(wb_waddr1),
    .wdata0(wb_wdata0), .wdata1(wb_wdata1)
  );

endmodule

// File: test/decode_tb.sv
module decode_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  localparam int num_cycles = 3000;
  localparam int reset_cycles = 4;
  localparam int period_ns = 40;
  localparam int run_limit_ns = (num_cycles + reset_cycles + 20) * period_ns;

  logic clock;
  logic reset;
  logic [31:0] fetch_pc0, fetch_pc1;
  logic [31:0] fetch_instr0, fetch_instr1;
  logic fetch_valid;
  logic pred_branch;
  logic clear;
  logic ex_load0, ex_load1;
  logic [4:0] ex_waddr0, ex_waddr1;
  logic ex_stall;
  logic wb_wren0, wb_wren1;
  logic [4:0] wb_waddr0, wb_waddr1;
  logic [31:0] wb_wdata0, wb_wdata1;
  logic [31:0] dec_pc0, dec_pc1;
  logic [31:0] dec_instr0, dec_instr1;
  logic [op_width-1:0] dec_flags0, dec_flags1;
  logic dec_valid0, dec_valid1;
  logic [31:0] dec_imm0, dec_imm1;
  logic [3:0] dec_alu_op0, dec_alu_op1;
  logic [2:0] dec_bcu_op0, dec_bcu_op1;
  logic [2:0] dec_lsu_op0, dec_lsu_op1;
  logic dec_exception0, dec_exception1;
  logic [3:0] dec_ecause0, dec_ecause1;
  logic [31:0] dec_rdata1_0, dec_rdata2_0, dec_rdata1_1, dec_rdata2_1;
  logic stall;

  // expected pair, one cycle behind the drive
  logic have_expect;
  logic e_stall;
  logic [31:0] e_pc [2];
  logic [31:0] e_instr [2];
  logic [op_width-1:0] e_flags [2];
  logic e_valid [2];
  logic e_exc [2];
  logic [3:0] e_cause [2];
  logic [31:0] e_imm [2];
  logic [3:0] e_alu [2];
  logic [2:0] e_bcu [2];
  logic [2:0] e_lsu [2];
  logic [31:0] model_regs [32];
  int checks;
  int errors;

  decode_top decode_top_inst (.*);

  ////////////////////
  // random helpers

  function automatic logic chance(input int unsigned pct);
    return ($urandom() % 100) < pct;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = $urandom();
    return r[4:0];
  endfunction

  function automatic logic [4:0] source_reg(input logic [31:0] w0, input logic [31:0] w1);
    case ($urandom() % 4)
      0: return w0[19:15];
      1: return w0[24:20];
      2: return w1[19:15];
      default: return w1[24:20];
    endcase
  endfunction

  // random word on a supported opcode, a few funct3 picks still illegal
  function automatic logic [31:0] legal_word();
    logic [31:0] w;
    w = $urandom();
    case ($urandom() % 10)
      0: w[6:0] = riscv_isa_pkg::op_lui;
      1: w[6:0] = riscv_isa_pkg::op_auipc;
      2: w[6:0] = riscv_isa_pkg::op_jal;
      3: w[6:0] = riscv_isa_pkg::op_jalr;
      4: w[6:0] = riscv_isa_pkg::op_branch;
      5: w[6:0] = riscv_isa_pkg::op_load;
      6: w[6:0] = riscv_isa_pkg::op_store;
      7: begin
        w[6:0] = op_imm;
        if (w[13:12] == 2'b01) begin
          w[31:25] = {1'b0, w[30], 5'b00000}; // shift amount form
        end
      end
      8: begin
        w[6:0] = op_reg;
        w[31:25] = {1'b0, w[30], 5'b00000};
      end
      default: w = chance(50) ? instr_ecall : instr_ebreak;
    endcase
    return w;
  endfunction

  ////////////////////
  // reference model

  function automatic logic [op_width-1:0] bit_of(input int idx);
    logic [op_width-1:0] b;
    b = '0;
    b[idx] = 1'b1;
    return b;
  endfunction

  function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? alu_sub : alu_add;
      3'd1: return alu_sll;
      3'd2: return alu_slt;
      3'd3: return alu_sltu;
      3'd4: return alu_xor;
      3'd5: return alt ? alu_sra : alu_srl;
      3'd6: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic void decode_ref(input logic [31:0] w, output logic [op_width-1:0] f,
                                     output logic v, output logic [31:0] im,
                                     output logic [3:0] alu, output logic [2:0] bcu,
                                     output logic [2:0] lsu);
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] imm_i;
    f3 = w[14:12];
    f7 = w[31:25];
    imm_i = 32'($signed(w[31:20]));
    f = '0;
    v = 1'b0;
    im = '0;
    alu = alu_add;
    bcu = 3'd0;
    lsu = 3'd0;
    case (w[6:0])
      riscv_isa_pkg::op_lui: begin
        f = bit_of(op_wren) | bit_of(decode_pkg::op_lui);
        im = {w[31:12], 12'd0};
        v = 1'b1;
      end
      riscv_isa_pkg::op_auipc: begin
        f = bit_of(op_wren) | bit_of(decode_pkg::op_auipc);
        im = {w[31:12], 12'd0};
        v = 1'b1;
      end
      riscv_isa_pkg::op_jal: begin
        f = bit_of(op_wren) | bit_of(decode_pkg::op_jal);
        im = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        v = 1'b1;
      end
      riscv_isa_pkg::op_jalr: begin
        f = bit_of(op_wren) | bit_of(op_rden1) | bit_of(decode_pkg::op_jalr);
        im = imm_i;
        v = f3 == 3'd0;
      end
      riscv_isa_pkg::op_branch: begin
        f = bit_of(op_rden1) | bit_of(op_rden2) | bit_of(decode_pkg::op_branch);
        im = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        bcu = f3;
        v = !(f3 inside {3'd2, 3'd3});
      end
      riscv_isa_pkg::op_load: begin
        f = bit_of(op_wren) | bit_of(op_rden1) | bit_of(decode_pkg::op_load);
        im = imm_i;
        lsu = f3;
        v = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      end
      riscv_isa_pkg::op_store: begin
        f = bit_of(op_rden1) | bit_of(op_rden2) | bit_of(decode_pkg::op_store);
        im = 32'($signed({w[31:25], w[11:7]}));
        lsu = f3;
        v = f3 inside {3'd0, 3'd1, 3'd2};
      end
      op_imm: begin
        f = bit_of(op_wren) | bit_of(op_rden1);
        im = imm_i;
        alu = alu_of(f3, f3 == 3'd5 && f7 == 7'h20);
        v = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
      end
      op_reg: begin
        f = bit_of(op_wren) | bit_of(op_rden1) | bit_of(op_rden2);
        alu = alu_of(f3, f7 == 7'h20);
        v = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end
      op_system: begin
        if (w == instr_ecall) begin
          f = bit_of(op_ecall);
          v = 1'b1;
        end else if (w == instr_ebreak) begin
          f = bit_of(op_ebreak);
          v = 1'b1;
        end
      end
      default: ;
    endcase
    if (!v) begin
      f = '0;
    end
  endfunction

  task automatic predict();
    logic [op_width-1:0] f0, f1;
    logic v0, v1;
    logic hz;
    logic bub;
    logic drop;
    logic ld;
    logic [4:0] dst;
    decode_ref(fetch_instr0, f0, v0, e_imm[0], e_alu[0], e_bcu[0], e_lsu[0]);
    decode_ref(fetch_instr1, f1, v1, e_imm[1], e_alu[1], e_bcu[1], e_lsu[1]);
    hz = 1'b0;
    for (int e = 0; e < 2; e++) begin
      ld = e == 0 ? ex_load0 : ex_load1;
      dst = e == 0 ? ex_waddr0 : ex_waddr1;
      if (ld && dst != 5'd0 && fetch_valid) begin
        if ((f0[op_rden1] && fetch_instr0[19:15] == dst) ||
            (f0[op_rden2] && fetch_instr0[24:20] == dst)) begin
          hz = 1'b1;
        end
        if (!pred_branch && ((f1[op_rden1] && fetch_instr1[19:15] == dst) ||
                             (f1[op_rden2] && fetch_instr1[24:20] == dst))) begin
          hz = 1'b1; // killed slot 1 never stalls
        end
      end
    end
    bub = hz | ex_stall | clear | ~fetch_valid;
    drop = bub | pred_branch;
    e_stall = hz & ~clear;
    e_pc[0] = fetch_pc0;
    e_pc[1] = fetch_pc1;
    e_instr[0] = fetch_instr0;
    e_instr[1] = pred_branch ? nop_instr : fetch_instr1;
    e_flags[0] = bub ? '0 : f0;
    e_flags[1] = drop ? '0 : f1;
    e_valid[0] = !bub && v0;
    e_valid[1] = !drop && v1;
    e_exc[0] = !bub && (!v0 || f0[op_ebreak] || f0[op_ecall]);
    e_exc[1] = !drop && !v1;
    if (!v0) begin
      e_cause[0] = except_illegal_instruction;
    end else if (f0[op_ebreak]) begin
      e_cause[0] = except_breakpoint;
    end else begin
      e_cause[0] = except_env_call_mach;
    end
    e_cause[1] = except_illegal_instruction;
  endtask

  ////////////////////
  // stimulus and checks

  task automatic idle_inputs();
    fetch_pc0 = '0;
    fetch_pc1 = '0;
    fetch_instr0 = nop_instr;
    fetch_instr1 = nop_instr;
    fetch_valid = 1'b0;
    pred_branch = 1'b0;
    clear = 1'b0;
    ex_load0 = 1'b0;
    ex_load1 = 1'b0;
    ex_waddr0 = '0;
    ex_waddr1 = '0;
    ex_stall = 1'b0;
    wb_wren0 = 1'b0;
    wb_wren1 = 1'b0;
    wb_waddr0 = '0;
    wb_waddr1 = '0;
    wb_wdata0 = '0;
    wb_wdata1 = '0;
  endtask

  task automatic drive_random();
    int pick;
    logic [31:0] r;
    pick = $urandom() % 100;
    r = $urandom();
    fetch_valid = chance(90);
    pred_branch = chance(20);
    clear = chance(6);
    ex_stall = chance(6);
    fetch_pc0 = {r[31:3], 3'b000};
    fetch_pc1 = fetch_pc0 + 32'd4;
    if (pick < 70) begin
      fetch_instr0 = legal_word();
    end else if (pick < 85) begin
      fetch_instr0 = $urandom(); // mostly illegal
    end else if (pick < 93) begin
      fetch_instr0 = instr_ecall;
    end else begin
      fetch_instr0 = instr_ebreak;
    end
    fetch_instr1 = chance(80) ? legal_word() : $urandom();
    ex_load0 = chance(30);
    ex_load1 = chance(30);
    ex_waddr0 = chance(50) ? source_reg(fetch_instr0, fetch_instr1) : rand_reg();
    ex_waddr1 = chance(50) ? source_reg(fetch_instr0, fetch_instr1) : rand_reg();
    wb_wren0 = chance(50);
    wb_wren1 = chance(50);
    wb_waddr0 = rand_reg();
    wb_waddr1 = chance(25) ? wb_waddr0 : rand_reg(); // same target now and then
    wb_wdata0 = $urandom();
    wb_wdata1 = $urandom();
  endtask

  // writes strobed at the last edge, slot 1 last so it wins
  task automatic apply_writeback();
    if (wb_wren0 && wb_waddr0 != 5'd0) begin
      model_regs[wb_waddr0] = wb_wdata0;
    end
    if (wb_wren1 && wb_waddr1 != 5'd0) begin
      model_regs[wb_waddr1] = wb_wdata1;
    end
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_slot(input int s, input logic [31:0] pc, input logic [31:0] instr,
                            input logic [op_width-1:0] flags, input logic valid,
                            input logic [31:0] imm, input logic [3:0] alu,
                            input logic [2:0] bcu, input logic [2:0] lsu, input logic exc,
                            input logic [3:0] cause, input logic [31:0] rdata1,
                            input logic [31:0] rdata2);
    compare($sformatf("dec_pc%0d", s), e_pc[s], pc);
    compare($sformatf("dec_instr%0d", s), e_instr[s], instr);
    compare($sformatf("dec_flags%0d", s), 32'(e_flags[s]), 32'(flags));
    compare($sformatf("dec_valid%0d", s), 32'(e_valid[s]), 32'(valid));
    compare($sformatf("dec_exception%0d", s), 32'(e_exc[s]), 32'(exc));
    if (e_exc[s]) begin
      compare($sformatf("dec_ecause%0d", s), 32'(e_cause[s]), 32'(cause));
    end
    if (e_valid[s]) begin
      compare($sformatf("dec_imm%0d", s), e_imm[s], imm);
      compare($sformatf("dec_alu_op%0d", s), 32'(e_alu[s]), 32'(alu));
      compare($sformatf("dec_bcu_op%0d", s), 32'(e_bcu[s]), 32'(bcu));
      compare($sformatf("dec_lsu_op%0d", s), 32'(e_lsu[s]), 32'(lsu));
    end
    compare($sformatf("dec_rdata1_%0d", s), model_regs[e_instr[s][19:15]], rdata1);
    compare($sformatf("dec_rdata2_%0d", s), model_regs[e_instr[s][24:20]], rdata2);
  endtask

  ////////////////////
  // clock, main run and watchdog

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  initial begin
    void'($urandom(32'haff1c554));
    idle_inputs();
    reset = 1'b0;
    have_expect = 1'b0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset = 1'b1;
    for (int n = 0; n < num_cycles; n++) begin
      @(posedge clock);
      #2;
      apply_writeback();
      if (have_expect) begin
        check_slot(0, dec_pc0, dec_instr0, dec_flags0, dec_valid0, dec_imm0, dec_alu_op0,
                   dec_bcu_op0, dec_lsu_op0, dec_exception0, dec_ecause0,
                   dec_rdata1_0, dec_rdata2_0);
        check_slot(1, dec_pc1, dec_instr1, dec_flags1, dec_valid1, dec_imm1, dec_alu_op1,
                   dec_bcu_op1, dec_lsu_op1, dec_exception1, dec_ecause1,
                   dec_rdata1_1, dec_rdata2_1);
      end
      drive_random();
      predict();
      have_expect = 1'b1;
      #1;
      compare("stall", 32'(e_stall), 32'(stall)); // combinational towards fetch
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(run_limit_ns);
    $display("watchdog expired before the test loop finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: compile.f
src/riscv_isa_pkg.sv
src/decode_pkg.sv
src/instr_decoder.sv
src/hazard_check.sv
src/register_file.sv
src/decode_stage.sv
src/decode_top.sv
test/decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f compile.f -o decode_tb

output=$(./obj_dir/decode_tb) || true
echo "$output"

if grep -qx "TESTS PASSED" <<< "$output"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
